// File: src/rvIsaPkg.sv
package rvIsaPkg;

    // Instruction word length of the base ISA
    localparam int instrWidth = 32;

    // Major opcode field, instruction bits 6 to 0
    typedef logic [6:0] opcode_t;

    // Upper immediate formats
    localparam opcode_t opLui    = 7'b0110111;
    localparam opcode_t opAuipc  = 7'b0010111;

    // Jumps
    localparam opcode_t opJal    = 7'b1101111;
    localparam opcode_t opJalr   = 7'b1100111;

    // Conditional branches, all six compare kinds
    localparam opcode_t opBranch = 7'b1100011;

    // Memory access, width chosen by funct3
    localparam opcode_t opLoad   = 7'b0000011;
    localparam opcode_t opStore  = 7'b0100011;

    // Integer ALU operations
    localparam opcode_t opImm    = 7'b0010011;
    localparam opcode_t opReg    = 7'b0110011;

    // Minor opcode fields
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Plain ALU operation
    localparam funct7_t f7Base   = 7'b0000000;

    // SUB, SRA and SRAI
    localparam funct7_t f7Alt    = 7'b0100000;

    // Multiply and divide of the M extension
    localparam funct7_t f7MulDiv = 7'b0000001;

    // Register file index, x0 to x31
    typedef logic [4:0] regAddr_t;

endpackage

// File: src/ctrlPkg.sv
package ctrlPkg;

    // Instruction class handed from main control to ALU control
    typedef logic [2:0] aluOp_t;

    // Address computation for loads and stores
    localparam aluOp_t aluOpMem    = 3'b000;
    localparam aluOp_t aluOpBranch = 3'b001;
    // Full funct3 and funct7 decode needed
    localparam aluOp_t aluOpArith  = 3'b010;
    localparam aluOp_t aluOpJal    = 3'b011;
    localparam aluOp_t aluOpLui    = 3'b100;
    localparam aluOp_t aluOpAuipc  = 3'b101;
    localparam aluOp_t aluOpJalr   = 3'b111;

    // Exact operation the execute stage performs
    typedef logic [4:0] aluCtrl_t;

    // Logic and add/sub
    localparam aluCtrl_t aluAnd    = 5'b00000;
    localparam aluCtrl_t aluOr     = 5'b00001;
    localparam aluCtrl_t aluAdd    = 5'b00010;
    localparam aluCtrl_t aluXor    = 5'b00011;
    localparam aluCtrl_t aluSub    = 5'b00100;

    // Shifts and compares, code 00101 unused
    localparam aluCtrl_t aluSll    = 5'b00110;
    localparam aluCtrl_t aluSrl    = 5'b00111;
    localparam aluCtrl_t aluSra    = 5'b01000;
    localparam aluCtrl_t aluSlt    = 5'b01001;
    localparam aluCtrl_t aluSltu   = 5'b01010;

    // M extension
    localparam aluCtrl_t aluMul    = 5'b01011;
    localparam aluCtrl_t aluMulh   = 5'b01100;
    localparam aluCtrl_t aluMulhsu = 5'b01101;
    localparam aluCtrl_t aluMulhu  = 5'b01110;
    localparam aluCtrl_t aluDiv    = 5'b01111;
    localparam aluCtrl_t aluDivu   = 5'b10000;
    localparam aluCtrl_t aluRem    = 5'b10001;
    localparam aluCtrl_t aluRemu   = 5'b10010;

endpackage

// File: src/immGen.sv
`timescale 1ns/1ps

module immGen #(
    parameter int xlen = 32
) (
    input  rvIsaPkg::opcode_t                  opcode,
    input  logic [rvIsaPkg::instrWidth-1:0]    instruction,
    output logic [xlen-1:0]                    imm
);

    // Immediate assembled at instruction width, sign bit is always bit 31
    logic signed [rvIsaPkg::instrWidth-1:0] immRaw;

    always_comb
    begin
        immRaw = '0;
        case (opcode)
            // I format
            rvIsaPkg::opJalr,
            rvIsaPkg::opLoad,
            rvIsaPkg::opImm:
                immRaw = {{20{instruction[31]}}, instruction[31:20]};

            // S format, offset split around rd position
            rvIsaPkg::opStore:
                immRaw = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};

            // B format, halfword aligned offset
            rvIsaPkg::opBranch:
            begin
                immRaw = {{19{instruction[31]}}, instruction[31], instruction[7],
                          instruction[30:25], instruction[11:8], 1'b0};
            end

            // U format
            rvIsaPkg::opLui,
            rvIsaPkg::opAuipc:
                immRaw = {instruction[31:12], 12'b0};

            // J format, bits scrambled as in the ISA
            rvIsaPkg::opJal:
            begin
                immRaw = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                          instruction[20], instruction[30:21], 1'b0};
            end

            // Register ops carry no immediate
            default:
                immRaw = '0;
        endcase
    end

    // Signed cast fills any wider register width with copies of bit 31
    assign imm = xlen'(immRaw);

endmodule

// File: src/mainControl.sv
`timescale 1ns/1ps

module mainControl (
    input  rvIsaPkg::opcode_t opcode,
    output logic              memWrite,
    output logic              memRead,
    output logic              regWrite,
    output logic              aluSrc,
    output logic              branch,
    output logic              memToReg,
    output ctrlPkg::aluOp_t   aluOp
);

    always_comb
    begin
        // NOP unless a known opcode matches
        memWrite = 1'b0;
        memRead  = 1'b0;
        regWrite = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        memToReg = 1'b0;
        aluOp    = ctrlPkg::aluOpMem;

        case (opcode)
            // rd gets the upper immediate
            rvIsaPkg::opLui:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = ctrlPkg::aluOpLui;
            end

            // rd gets pc plus upper immediate
            rvIsaPkg::opAuipc:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = ctrlPkg::aluOpAuipc;
            end

            // Link write is handled downstream via memToReg path
            rvIsaPkg::opJal:
            begin
                aluSrc   = 1'b1;
                branch   = 1'b1;
                memToReg = 1'b1;
                aluOp    = ctrlPkg::aluOpJal;
            end

            rvIsaPkg::opJalr:
            begin
                aluSrc   = 1'b1;
                branch   = 1'b1;
                memToReg = 1'b1;
                aluOp    = ctrlPkg::aluOpJalr;
            end

            // Compare of two registers, target from immediate
            rvIsaPkg::opBranch:
            begin
                branch = 1'b1;
                aluOp  = ctrlPkg::aluOpBranch;
            end

            // Address is rs1 plus offset, data back from memory
            rvIsaPkg::opLoad:
            begin
                regWrite = 1'b1;
                memRead  = 1'b1;
                aluSrc   = 1'b1;
                memToReg = 1'b1;
                aluOp    = ctrlPkg::aluOpMem;
            end

            rvIsaPkg::opStore:
            begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = ctrlPkg::aluOpMem;
            end

            // Second operand from immediate
            rvIsaPkg::opImm:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = ctrlPkg::aluOpArith;
            end

            // Second operand from rs2
            rvIsaPkg::opReg:
            begin
                regWrite = 1'b1;
                aluOp    = ctrlPkg::aluOpArith;
            end

            default:
            begin
                // Unknown or dropped opcodes stay a NOP
                aluOp = ctrlPkg::aluOpMem;
            end
        endcase
    end

endmodule

// File: src/aluControl.sv
`timescale 1ns/1ps

module aluControl (
    input  ctrlPkg::aluOp_t    aluOp,
    input  logic               aluSrc,
    input  rvIsaPkg::funct3_t  funct3,
    input  rvIsaPkg::funct7_t  funct7,
    output ctrlPkg::aluCtrl_t  aluCtrl
);

    // Register form of an arith op, the only form where funct7 is a real field
    logic regOp;
    // M extension only exists in register form
    logic mulDivOp;
    // SUB and SRA marker
    logic altOp;

    assign regOp    = ~aluSrc;
    assign mulDivOp = regOp && (funct7 == rvIsaPkg::f7MulDiv);
    assign altOp    = (funct7 == rvIsaPkg::f7Alt);

    always_comb
    begin
        // Address and link computations are plain adds
        aluCtrl = ctrlPkg::aluAdd;

        case (aluOp)
            // Branch compare done as subtraction
            ctrlPkg::aluOpBranch:
                aluCtrl = ctrlPkg::aluSub;

            ctrlPkg::aluOpArith:
            begin
                if (mulDivOp)
                begin
                    // Multiply and divide selected by funct3 alone
                    case (funct3)
                        3'b000:  aluCtrl = ctrlPkg::aluMul;
                        3'b001:  aluCtrl = ctrlPkg::aluMulh;
                        3'b010:  aluCtrl = ctrlPkg::aluMulhsu;
                        3'b011:  aluCtrl = ctrlPkg::aluMulhu;
                        3'b100:  aluCtrl = ctrlPkg::aluDiv;
                        3'b101:  aluCtrl = ctrlPkg::aluDivu;
                        3'b110:  aluCtrl = ctrlPkg::aluRem;
                        default: aluCtrl = ctrlPkg::aluRemu;
                    endcase
                end
                else
                begin
                    case (funct3)
                        // ADDI has no SUBI, so the alt bit counts only for registers
                        3'b000:
                        begin
                            if (regOp && altOp)
                                aluCtrl = ctrlPkg::aluSub;
                            else
                                aluCtrl = ctrlPkg::aluAdd;
                        end
                        3'b001:  aluCtrl = ctrlPkg::aluSll;
                        3'b010:  aluCtrl = ctrlPkg::aluSlt;
                        3'b011:  aluCtrl = ctrlPkg::aluSltu;
                        3'b100:  aluCtrl = ctrlPkg::aluXor;
                        // SRAI keeps funct7 in the upper immediate bits
                        3'b101:
                        begin
                            if (altOp)
                                aluCtrl = ctrlPkg::aluSra;
                            else
                                aluCtrl = ctrlPkg::aluSrl;
                        end
                        3'b110:  aluCtrl = ctrlPkg::aluOr;
                        default: aluCtrl = ctrlPkg::aluAnd;
                    endcase
                end
            end

            // Mem, jumps, LUI and AUIPC
            default:
                aluCtrl = ctrlPkg::aluAdd;
        endcase
    end

endmodule

// File: src/decodeStage.sv
`timescale 1ns/1ps

module decodeStage #(
    parameter int xlen = 32
) (
    input  logic                              clk,
    input  logic                              rst,

    // Fetch side and register bank read data
    input  logic [rvIsaPkg::instrWidth-1:0]   nextInstruction,
    input  logic [xlen-1:0]                   regValue1,
    input  logic [xlen-1:0]                   regValue2,

    // Register addresses
    output rvIsaPkg::regAddr_t                rs1,
    output rvIsaPkg::regAddr_t                rs2,
    output rvIsaPkg::regAddr_t                regDest,

    // Operands for execute
    output logic [xlen-1:0]                   imm,
    output logic [xlen-1:0]                   value1,
    output logic [xlen-1:0]                   value2,

    // Main controls
    output logic                              memWrite,
    output logic                              memRead,
    output logic                              regWrite,
    output logic                              aluSrc,
    output logic                              branch,
    output logic                              memToReg,
    output ctrlPkg::aluOp_t                   aluOp,
    output ctrlPkg::aluCtrl_t                 aluCtrl
);

    // Held instruction word
    logic [rvIsaPkg::instrWidth-1:0] instrReg;

    // Fields sliced from the held word
    rvIsaPkg::opcode_t opcode;
    rvIsaPkg::funct3_t funct3;
    rvIsaPkg::funct7_t funct7;

    // Pipeline register, one instruction per clock, no stall
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            // Opcode zero decodes as NOP
            instrReg <= '0;
            value1   <= '0;
            value2   <= '0;
        end
        else
        begin
            instrReg <= nextInstruction;
            value1   <= regValue1;
            value2   <= regValue2;
        end
    end

    // Field positions are shared by all formats
    assign opcode  = instrReg[6:0];
    assign regDest = instrReg[11:7];
    assign funct3  = instrReg[14:12];
    assign rs1     = instrReg[19:15];
    assign rs2     = instrReg[24:20];
    assign funct7  = instrReg[31:25];

    // Sign-extended immediate
    immGen #(
        .xlen        (xlen)
    ) i_immGen (
        .opcode      (opcode),
        .instruction (instrReg),
        .imm         (imm)
    );

    // Opcode to control tuple
    mainControl i_mainControl (
        .opcode   (opcode),
        .memWrite (memWrite),
        .memRead  (memRead),
        .regWrite (regWrite),
        .aluSrc   (aluSrc),
        .branch   (branch),
        .memToReg (memToReg),
        .aluOp    (aluOp)
    );

    // Class plus funct fields to exact operation
    aluControl i_aluControl (
        .aluOp   (aluOp),
        .aluSrc  (aluSrc),
        .funct3  (funct3),
        .funct7  (funct7),
        .aluCtrl (aluCtrl)
    );

endmodule

// File: bench/decodeStage_props.sv
`timescale 1ns/1ps

module decodeStageProps (
    input logic            clk,
    input logic            rst,
    input logic            memWrite,
    input logic            memRead,
    input logic            regWrite,
    input logic            aluSrc,
    input logic            branch,
    input logic            memToReg,
    input ctrlPkg::aluOp_t aluOp
);

    // Loads always return memory data to rd
    loadUsesMemData: assert property (@(posedge clk) disable iff (rst) memRead |-> memToReg)
        else $error("memRead high without memToReg");

    // One memory access per instruction
    noReadWriteClash: assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite))
        else $error("memRead and memWrite high together");

    // Jumps and branches never raise regWrite here
    branchNoRegWrite: assert property (@(posedge clk) disable iff (rst) branch |-> !regWrite)
        else $error("branch high together with regWrite");

    // First edge after reset release still sees the cleared register
    quietAfterReset: assert property (@(posedge clk)
        (!rst && $past(rst)) |->
            !(memWrite || memRead || regWrite || aluSrc || branch || memToReg)
            && (aluOp == ctrlPkg::aluOpMem))
        else $error("controls not low right after reset release");

endmodule

// File: bench/decodeStageTb.sv
`timescale 1ns/1ps

module decodeStageTb;

    localparam int xlen        = 32;
    localparam int clkPeriod   = 8;
    localparam int resetCycles = 5;
    localparam int numTests    = 600;

    // Expected view of every DUT output
    typedef struct packed {
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      regDest;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] value1;
        logic [xlen-1:0] value2;
        logic            regWrite;
        logic            memRead;
        logic            memWrite;
        logic            aluSrc;
        logic            branch;
        logic            memToReg;
        logic [2:0]      aluOp;
        logic [4:0]      aluCtrl;
    } decodeOut_t;

    logic clk;
    logic rst;
    logic [31:0] nextInstruction;
    logic [xlen-1:0] regValue1;
    logic [xlen-1:0] regValue2;

    rvIsaPkg::regAddr_t rs1;
    rvIsaPkg::regAddr_t rs2;
    rvIsaPkg::regAddr_t regDest;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] value1;
    logic [xlen-1:0] value2;
    logic memWrite;
    logic memRead;
    logic regWrite;
    logic aluSrc;
    logic branch;
    logic memToReg;
    ctrlPkg::aluOp_t aluOp;
    ctrlPkg::aluCtrl_t aluCtrl;

    logic [15:0] lfsrState;
    decodeOut_t expectedQ[$];
    int checkedCount = 0;

    decodeStage #(
        .xlen            (xlen)
    ) i_decodeStage (
        .clk             (clk),
        .rst             (rst),
        .nextInstruction (nextInstruction),
        .regValue1       (regValue1),
        .regValue2       (regValue2),
        .rs1             (rs1),
        .rs2             (rs2),
        .regDest         (regDest),
        .imm             (imm),
        .value1          (value1),
        .value2          (value2),
        .memWrite        (memWrite),
        .memRead         (memRead),
        .regWrite        (regWrite),
        .aluSrc          (aluSrc),
        .branch          (branch),
        .memToReg        (memToReg),
        .aluOp           (aluOp),
        .aluCtrl         (aluCtrl)
    );

    // Control consistency checks ride along inside the DUT
    bind decodeStage decodeStageProps i_props (
        .clk      (clk),
        .rst      (rst),
        .memWrite (memWrite),
        .memRead  (memRead),
        .regWrite (regWrite),
        .aluSrc   (aluSrc),
        .branch   (branch),
        .memToReg (memToReg),
        .aluOp    (aluOp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic takeBits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsrState = lfsrStep(lfsrState);
            bits = {bits[30:0], lfsrState[0]};
        end
    endtask

    function automatic rvIsaPkg::opcode_t keptOpcode(input int idx);
        case (idx)
            0:       return rvIsaPkg::opLui;
            1:       return rvIsaPkg::opAuipc;
            2:       return rvIsaPkg::opJal;
            3:       return rvIsaPkg::opJalr;
            4:       return rvIsaPkg::opBranch;
            5:       return rvIsaPkg::opLoad;
            6:       return rvIsaPkg::opStore;
            7:       return rvIsaPkg::opImm;
            default: return rvIsaPkg::opReg;
        endcase
    endfunction

    // Random fields, opcode from the kept set, now and then SYSTEM, FENCE or junk
    task automatic makeInstruction(output logic [31:0] instr);
        logic [31:0] bits;
        logic [31:0] pick;
        rvIsaPkg::opcode_t op;
        takeBits(32, bits);
        takeBits(4, pick);
        if (pick < 9)
            op = keptOpcode(pick);
        else if (pick == 15)
        begin
            takeBits(2, pick);
            case (pick[1:0])
                2'd0:    op = 7'b1110011;
                2'd1:    op = 7'b0001111;
                2'd2:    op = 7'b0000000;
                default: op = 7'b1111111;
            endcase
        end
        else
            op = keptOpcode(pick - 9);
        if (op == rvIsaPkg::opReg)
        begin
            takeBits(2, pick);
            case (pick[1:0])
                2'd0:    bits[31:25] = rvIsaPkg::f7Base;
                2'd1:    bits[31:25] = rvIsaPkg::f7Alt;
                default: bits[31:25] = rvIsaPkg::f7MulDiv;
            endcase
        end
        else if (op == rvIsaPkg::opImm)
        begin
            // Half the time hit SRAI
            takeBits(1, pick);
            if (pick[0])
                bits[31:25] = rvIsaPkg::f7Alt;
        end
        instr = {bits[31:7], op};
    endtask

    // Expected outputs straight from the ISA formats and the decode tables
    function automatic decodeOut_t predictDecode(
        input logic [31:0]     instr,
        input logic [xlen-1:0] v1,
        input logic [xlen-1:0] v2
    );
        decodeOut_t want;
        rvIsaPkg::opcode_t opc;
        rvIsaPkg::funct3_t f3;
        rvIsaPkg::funct7_t f7;
        logic [8:0] ctl;
        logic isReg;
        opc = instr[6:0];
        f3 = instr[14:12];
        f7 = instr[31:25];
        isReg = (opc == rvIsaPkg::opReg);
        want = '0;
        want.rs1 = instr[19:15];
        want.rs2 = instr[24:20];
        want.regDest = instr[11:7];
        want.value1 = v1;
        want.value2 = v2;

        // regWrite memRead memWrite aluSrc branch memToReg, then aluOp
        case (opc)
            rvIsaPkg::opLui:    ctl = {6'b100100, ctrlPkg::aluOpLui};
            rvIsaPkg::opAuipc:  ctl = {6'b100100, ctrlPkg::aluOpAuipc};
            rvIsaPkg::opJal:    ctl = {6'b000111, ctrlPkg::aluOpJal};
            rvIsaPkg::opJalr:   ctl = {6'b000111, ctrlPkg::aluOpJalr};
            rvIsaPkg::opBranch: ctl = {6'b000010, ctrlPkg::aluOpBranch};
            rvIsaPkg::opLoad:   ctl = {6'b110101, ctrlPkg::aluOpMem};
            rvIsaPkg::opStore:  ctl = {6'b001100, ctrlPkg::aluOpMem};
            rvIsaPkg::opImm:    ctl = {6'b100100, ctrlPkg::aluOpArith};
            rvIsaPkg::opReg:    ctl = {6'b100000, ctrlPkg::aluOpArith};
            default:            ctl = {6'b000000, ctrlPkg::aluOpMem};
        endcase
        {want.regWrite, want.memRead, want.memWrite, want.aluSrc,
         want.branch, want.memToReg, want.aluOp} = ctl;

        // Sign extension via signed size casts
        case (opc)
            rvIsaPkg::opJalr,
            rvIsaPkg::opLoad,
            rvIsaPkg::opImm:    want.imm = xlen'($signed(instr[31:20]));
            rvIsaPkg::opStore:  want.imm = xlen'($signed({instr[31:25], instr[11:7]}));
            rvIsaPkg::opBranch:
                want.imm = xlen'($signed({instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}));
            rvIsaPkg::opLui,
            rvIsaPkg::opAuipc:  want.imm = xlen'($signed({instr[31:12], 12'h000}));
            rvIsaPkg::opJal:
                want.imm = xlen'($signed({instr[31], instr[19:12], instr[20], instr[30:21], 1'b0}));
            default:            want.imm = '0;
        endcase

        if (want.aluOp == ctrlPkg::aluOpBranch)
            want.aluCtrl = ctrlPkg::aluSub;
        else if (want.aluOp != ctrlPkg::aluOpArith)
            want.aluCtrl = ctrlPkg::aluAdd;
        else if (isReg && f7 == rvIsaPkg::f7MulDiv)
        begin
            case (f3)
                3'b000:  want.aluCtrl = ctrlPkg::aluMul;
                3'b001:  want.aluCtrl = ctrlPkg::aluMulh;
                3'b010:  want.aluCtrl = ctrlPkg::aluMulhsu;
                3'b011:  want.aluCtrl = ctrlPkg::aluMulhu;
                3'b100:  want.aluCtrl = ctrlPkg::aluDiv;
                3'b101:  want.aluCtrl = ctrlPkg::aluDivu;
                3'b110:  want.aluCtrl = ctrlPkg::aluRem;
                default: want.aluCtrl = ctrlPkg::aluRemu;
            endcase
        end
        else
        begin
            case (f3)
                3'b000:
                    want.aluCtrl = (isReg && f7 == rvIsaPkg::f7Alt) ? ctrlPkg::aluSub
                                                                    : ctrlPkg::aluAdd;
                3'b001:  want.aluCtrl = ctrlPkg::aluSll;
                3'b010:  want.aluCtrl = ctrlPkg::aluSlt;
                3'b011:  want.aluCtrl = ctrlPkg::aluSltu;
                3'b100:  want.aluCtrl = ctrlPkg::aluXor;
                3'b101:
                    want.aluCtrl = (f7 == rvIsaPkg::f7Alt) ? ctrlPkg::aluSra : ctrlPkg::aluSrl;
                3'b110:  want.aluCtrl = ctrlPkg::aluOr;
                default: want.aluCtrl = ctrlPkg::aluAnd;
            endcase
        end
        return want;
    endfunction

    task automatic checkValue(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic compareOutputs(input decodeOut_t want);
        checkValue("rs1", 32'(rs1), 32'(want.rs1));
        checkValue("rs2", 32'(rs2), 32'(want.rs2));
        checkValue("regDest", 32'(regDest), 32'(want.regDest));
        checkValue("imm", imm, want.imm);
        checkValue("value1", value1, want.value1);
        checkValue("value2", value2, want.value2);
        checkValue("regWrite", 32'(regWrite), 32'(want.regWrite));
        checkValue("memRead", 32'(memRead), 32'(want.memRead));
        checkValue("memWrite", 32'(memWrite), 32'(want.memWrite));
        checkValue("aluSrc", 32'(aluSrc), 32'(want.aluSrc));
        checkValue("branch", 32'(branch), 32'(want.branch));
        checkValue("memToReg", 32'(memToReg), 32'(want.memToReg));
        checkValue("aluOp", 32'(aluOp), 32'(want.aluOp));
        checkValue("aluCtrl", 32'(aluCtrl), 32'(want.aluCtrl));
        checkedCount++;
    endtask

    // Entry driven at edge N is visible after edge N+1, so check it one negedge late
    initial
    begin : compareProc
        decodeOut_t prevWant;
        logic prevValid;
        prevValid = 1'b0;
        forever
        begin
            @(negedge clk);
            if (prevValid)
                compareOutputs(prevWant);
            prevValid = (expectedQ.size() > 0);
            if (prevValid)
                prevWant = expectedQ.pop_front();
        end
    end

    // Stimulus, back to back with no idle cycles
    initial
    begin
        logic [31:0] instr;
        logic [31:0] v1;
        logic [31:0] v2;
        decodeOut_t resetWant;
        rst = 1'b1;
        // Live load word and operands held during reset, none of it may leak out
        nextInstruction = {12'hfff, 5'd2, 3'b010, 5'd1, rvIsaPkg::opLoad};
        regValue1 = 32'h1234_5678;
        regValue2 = 32'h9abc_def0;
        lfsrState = 16'd40;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        nextInstruction <= '0;
        regValue1 <= '0;
        regValue2 <= '0;

        // Register still cleared, first edge out of reset not yet seen
        @(negedge clk);
        resetWant = '0;
        resetWant.aluCtrl = ctrlPkg::aluAdd;
        compareOutputs(resetWant);

        for (int n = 0; n < numTests; n++)
        begin
            @(posedge clk);
            makeInstruction(instr);
            takeBits(32, v1);
            takeBits(32, v2);
            nextInstruction <= instr;
            regValue1 <= v1;
            regValue2 <= v2;
            expectedQ.push_back(predictDecode(instr, v1, v2));
        end

        // Last entry is checked on the second negedge
        repeat (3) @(negedge clk);
        checkValue("checkedCount", checkedCount, numTests + 1);
        $display("No errors");
        $finish;
    end

    // Watchdog
    initial
    begin
        #((numTests + resetCycles + 50) * clkPeriod);
        $display("Timeout: the run did not finish within the expected time");
        $display("Errors found");
        $fatal(1);
    end

endmodule

// File: all.f
src/rvIsaPkg.sv
src/ctrlPkg.sv
src/immGen.sv
src/mainControl.sv
src/aluControl.sv
src/decodeStage.sv
bench/decodeStage_props.sv
bench/decodeStageTb.sv

// File: Makefile
VERILATOR = verilator
SIMFLAGS  = --binary --timing --assert
LINTFLAGS = --lint-only --timing --assert
TOP       = decodeStageTb
FILELIST  = all.f
BUILDDIR  = obj_dir
LOG       = sim.log
FAILMSG   = Errors found
PASSMSG   = No errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR) -o $(TOP)
	-./$(BUILDDIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILDDIR) $(LOG)
